// ==== build.f ====
+incdir+include
verilog/hd44780_pkg.sv
verilog/lcd_driver_pkg.sv
verilog/init_sequencer.sv
verilog/message_sequencer.sv
verilog/bus_arbiter.sv
verilog/nibble_framer.sv
verilog/lcd_top.sv
dv/lcd_top_tb.sv

// ==== dv/lcd_input.txt ====
// columns: test name, message select (decimal), expected eight characters
// selects 6 and 7 share the error text, the last two lines repeat earlier messages
weather          0 Weather#
hazelnut         1 Hazelnut
cookie           2 Cookie##
rulokat          3 Rulokat#
salad            4 Salad###
orange           5 Orange##
error_sel6       6 Error###
error_sel7       7 Error###
repeat_hazelnut  1 Hazelnut
repeat_weather   0 Weather#

// ==== dv/lcd_top_tb.sv ====
`default_nettype none

module lcd_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 4000;  // cycles allowed for any single wait
    localparam int HOLD_CYCLES = 6;     // start_lcd kept high after done

    logic       clk = 1'b0;
    logic       counter_reset;
    logic       start_lcd;
    logic [2:0] selective;
    logic       exp_ready;
    logic [7:0] exp_data;
    logic       exp_valid;
    logic       busy;
    logic       done;

    logic [7:0]  exp_q[$];      // bytes still expected on the bus
    string       cur_test;
    int          xfer_count;    // transfers seen since time zero
    int          test_base;     // xfer_count at the start of the current test
    int          value_errors;
    int          other_errors;
    bit          timed_out;
    logic [31:0] rng_state;
    logic        pending;       // transfer at the coming rising edge
    logic [7:0]  pending_data;
    logic        stall_prev;    // byte held back at the last rising edge
    logic [7:0]  stall_data;
    logic [7:0]  want_byte;

    lcd_top #(
        .POWER_UP_CYCLES (20),
        .INIT_GAP_CYCLES (6),
        .CHAR_GAP_CYCLES (3)
    ) u_lcd_top (
        .clk           (clk),
        .counter_reset (counter_reset),
        .start_lcd     (start_lcd),
        .selective     (selective),
        .exp_ready     (exp_ready),
        .exp_data      (exp_data),
        .exp_valid     (exp_valid),
        .busy          (busy),
        .done          (done)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // nibble on top, backlight on, write, register select in bit 0
    function automatic logic [7:0] frame_byte(input logic [3:0] nib, input logic en,
                                              input logic rs);
        return {nib, 1'b1, en, 1'b0, rs};
    endfunction

    task automatic push_nibble(input logic [3:0] nib, input logic rs);
        exp_q.push_back(frame_byte(nib, 1'b1, rs));  // enable high
        exp_q.push_back(frame_byte(nib, 1'b0, rs));  // enable low
    endtask

    task automatic push_byte(input logic [7:0] b, input logic rs);
        push_nibble(b[7:4], rs);
        push_nibble(b[3:0], rs);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s in test %s", what, cur_test);
        other_errors++;
        timed_out = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // expander bus, ready and byte checker
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (stall_prev) begin
            check_value($sformatf("%s stall valid", cur_test), 32'd1, exp_valid);
            check_value($sformatf("%s stall data", cur_test), stall_data, exp_data);
        end
        rng_state    = xorshift32(rng_state);
        exp_ready    = (rng_state[1:0] != 2'b00);  // low about one cycle in four
        pending      = exp_valid && exp_ready;
        pending_data = exp_data;
        stall_prev   = exp_valid && !exp_ready;
        stall_data   = exp_data;
    end

    always @(posedge clk) begin
        if (pending) begin
            if (exp_q.size() == 0) begin
                $display("unexpected byte 0x%02h on the expander bus during %s",
                         pending_data, cur_test);
                other_errors++;
            end else begin
                want_byte = exp_q.pop_front();
                check_value($sformatf("%s byte %0d", cur_test, xfer_count - test_base),
                            want_byte, pending_data);
            end
            xfer_count++;
        end
    end

    //////////////////////////////////////////////////
    // test steps
    //////////////////////////////////////////////////

    task automatic run_init();
        int cycles;
        cur_test  = "init";
        test_base = xfer_count;
        for (int n = 0; n < 4; n++) begin
            push_nibble((n == 3) ? 4'h2 : 4'h3, 1'b0);  // three wake-ups, then 4-bit mode
        end
        cycles = 0;
        while (xfer_count < test_base + 8 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            check_value("init busy", 32'd0, busy);
            check_value("init done", 32'd0, done);
            cycles++;
        end
        if (xfer_count < test_base + 8) begin
            report_timeout("the initialization bytes");
        end
    endtask

    task automatic run_message(input string name, input logic [2:0] sel, input string text);
        int cycles;
        int total;
        cur_test  = name;
        test_base = xfer_count;
        total     = 4 * (2 + text.len());
        push_byte(8'h0F, 1'b0);  // display on, blinking cursor
        push_byte(8'h80, 1'b0);  // ddram address 0
        for (int k = 0; k < text.len(); k++) begin
            push_byte(text[k], 1'b1);
        end
        @(negedge clk);
        selective = sel;
        start_lcd = 1'b1;

        cycles = 0;
        while (busy !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            check_value($sformatf("%s done before busy", name), 32'd0, done);
            cycles++;
        end
        if (busy !== 1'b1) begin
            report_timeout("busy");
            return;
        end

        cycles = 0;
        while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
            check_value($sformatf("%s busy", name), 32'd1, busy);
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            report_timeout("done");
            return;
        end
        check_value($sformatf("%s busy with done", name), 32'd0, busy);
        check_value($sformatf("%s byte count", name), test_base + total, xfer_count);
        check_value($sformatf("%s bytes missing", name), 32'd0, exp_q.size());

        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value($sformatf("%s done held", name), 32'd1, done);
        end
        start_lcd = 1'b0;
        cycles = 0;
        while (done !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b0) begin
            report_timeout("done to fall");
            return;
        end
        check_value($sformatf("%s done fall latency", name), 32'd1, cycles);
        check_value($sformatf("%s bytes after done", name), test_base + total, xfer_count);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int    fd;
        int    code;
        int    fields;
        int    t_sel;
        string line;
        string t_name;
        string t_text;
        string names[$];
        int    sels[$];
        string texts[$];

        counter_reset = 1'b1;
        start_lcd     = 1'b0;
        selective     = 3'd0;
        exp_ready     = 1'b0;
        rng_state     = 32'd45746;
        pending       = 1'b0;
        pending_data  = 8'h00;
        stall_prev    = 1'b0;
        stall_data    = 8'h00;
        want_byte     = 8'h00;
        xfer_count    = 0;
        test_base     = 0;
        value_errors  = 0;
        other_errors  = 0;
        timed_out     = 1'b0;
        cur_test      = "reset";

        fd = $fopen("dv/lcd_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/lcd_input.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                    fields = $sscanf(line, "%s %d %s", t_name, t_sel, t_text);
                    if (fields == 3 && t_text.len() == 8) begin
                        names.push_back(t_name);
                        sels.push_back(t_sel);
                        texts.push_back(t_text);
                    end else begin
                        $display("malformed line in dv/lcd_input.txt: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                $display("no tests found in dv/lcd_input.txt");
                other_errors++;
            end
        end

        repeat (3) @(negedge clk);
        counter_reset = 1'b0;

        run_init();
        for (int i = 0; i < names.size(); i++) begin
            if (!timed_out) begin
                run_message(names[i], sels[i], texts[i]);
            end
        end
        repeat (20) @(negedge clk);  // room for a stray byte to show up

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/lcd_top.sv ====
`default_nettype none

module lcd_top #(
    parameter int POWER_UP_CYCLES = 1000000,  // 20 ms at 50 MHz
    parameter int INIT_GAP_CYCLES = 250000,   // 5 ms
    parameter int CHAR_GAP_CYCLES = 150000    // 3 ms
) (
    input  logic                   clk,
    input  logic                   counter_reset,
    input  logic                   start_lcd,
    input  lcd_driver_pkg::sel_t   selective,
    input  logic                   exp_ready,
    output hd44780_pkg::exp_byte_t exp_data,
    output logic                   exp_valid,
    output logic                   busy,
    output logic                   done
);
    import hd44780_pkg::*;

    logic    init_req;
    logic    init_ack;
    logic    init_done;
    nibble_t init_nibble;
    rs_e     init_rs;

    logic    msg_req;
    logic    msg_ack;
    nibble_t msg_nibble;
    rs_e     msg_rs;

    logic    fr_req;
    logic    fr_ack;
    nibble_t fr_nibble;
    rs_e     fr_rs;

    //////////////////////////////////////////////////
    // two sequencers sharing one framer
    //////////////////////////////////////////////////

    init_sequencer #(
        .POWER_UP_CYCLES (POWER_UP_CYCLES),
        .INIT_GAP_CYCLES (INIT_GAP_CYCLES)
    ) u_init_sequencer (
        .clk           (clk),
        .counter_reset (counter_reset),
        .init_ack      (init_ack),
        .init_req      (init_req),
        .init_nibble   (init_nibble),
        .init_rs       (init_rs),
        .init_done     (init_done)
    );

    message_sequencer #(
        .CHAR_GAP_CYCLES (CHAR_GAP_CYCLES)
    ) u_message_sequencer (
        .clk           (clk),
        .counter_reset (counter_reset),
        .start_lcd     (start_lcd),
        .selective     (selective),
        .init_done     (init_done),
        .msg_ack       (msg_ack),
        .msg_req       (msg_req),
        .msg_nibble    (msg_nibble),
        .msg_rs        (msg_rs),
        .busy          (busy),
        .done          (done)
    );

    bus_arbiter u_bus_arbiter (
        .clk           (clk),
        .counter_reset (counter_reset),
        .init_req      (init_req),
        .init_nibble   (init_nibble),
        .init_rs       (init_rs),
        .msg_req       (msg_req),
        .msg_nibble    (msg_nibble),
        .msg_rs        (msg_rs),
        .fr_ack        (fr_ack),
        .init_ack      (init_ack),
        .msg_ack       (msg_ack),
        .fr_req        (fr_req),
        .fr_nibble     (fr_nibble),
        .fr_rs         (fr_rs)
    );

    nibble_framer u_nibble_framer (
        .clk           (clk),
        .counter_reset (counter_reset),
        .fr_req        (fr_req),
        .fr_nibble     (fr_nibble),
        .fr_rs         (fr_rs),
        .exp_ready     (exp_ready),
        .fr_ack        (fr_ack),
        .exp_data      (exp_data),
        .exp_valid     (exp_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/nibble_framer.sv ====
`default_nettype none

module nibble_framer (
    input  logic                   clk,
    input  logic                   counter_reset,
    input  logic                   fr_req,
    input  hd44780_pkg::nibble_t   fr_nibble,
    input  hd44780_pkg::rs_e       fr_rs,
    input  logic                   exp_ready,
    output logic                   fr_ack,
    output hd44780_pkg::exp_byte_t exp_data,
    output logic                   exp_valid
);
    import hd44780_pkg::*;

    nibble_t nib_q;
    rs_e     rs_q;
    logic    en_q;    // enable bit of the byte on offer
    logic    accept;
    logic    xfer;

    // no new request during the ack cycle, the requester still holds req there
    assign accept = fr_req && !exp_valid && !fr_ack;
    assign xfer   = exp_valid && exp_ready;

    always_comb begin
        exp_data                = '0;
        exp_data[7:4]           = nib_q;
        exp_data[EXP_BACKLIGHT] = 1'b1;
        exp_data[EXP_ENABLE]    = en_q;
        exp_data[EXP_RW]        = 1'b0;  // write only
        exp_data[EXP_RS]        = rs_q;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            nib_q <= fr_nibble;
            rs_q  <= fr_rs;
        end
    end

    //////////////////////////////////////////////////
    // enable pulse, high byte then low byte
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (counter_reset) begin
            exp_valid <= 1'b0;
            en_q      <= 1'b0;
            fr_ack    <= 1'b0;
        end else begin
            fr_ack <= 1'b0;
            if (accept) begin
                exp_valid <= 1'b1;
                en_q      <= 1'b1;
            end else if (xfer) begin
                if (en_q) begin
                    en_q <= 1'b0;  // display latches the nibble on this fall
                end else begin
                    exp_valid <= 1'b0;
                    fr_ack    <= 1'b1;
                end
            end
        end
    end

    // a stalled byte stays on the bus unchanged
    assert property (@(posedge clk) disable iff (counter_reset)
        exp_valid && !exp_ready |=> exp_valid && $stable(exp_data));

endmodule

`default_nettype wire

// ==== verilog/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
    input  logic                 clk,
    input  logic                 counter_reset,
    input  logic                 init_req,
    input  hd44780_pkg::nibble_t init_nibble,
    input  hd44780_pkg::rs_e     init_rs,
    input  logic                 msg_req,
    input  hd44780_pkg::nibble_t msg_nibble,
    input  hd44780_pkg::rs_e     msg_rs,
    input  logic                 fr_ack,
    output logic                 init_ack,
    output logic                 msg_ack,
    output logic                 fr_req,
    output hd44780_pkg::nibble_t fr_nibble,
    output hd44780_pkg::rs_e     fr_rs
);

    logic gnt_valid;  // framer is owned by one requester
    logic gnt_msg;    // owner is the message sequencer
    logic sel_msg;

    // a held grant wins, otherwise init goes first
    assign sel_msg = gnt_valid ? gnt_msg : (msg_req && !init_req);

    assign fr_req    = sel_msg ? msg_req    : init_req;
    assign fr_nibble = sel_msg ? msg_nibble : init_nibble;
    assign fr_rs     = sel_msg ? msg_rs     : init_rs;
    assign init_ack  = fr_ack && !sel_msg;
    assign msg_ack   = fr_ack && sel_msg;

    always_ff @(posedge clk) begin
        if (counter_reset) begin
            gnt_valid <= 1'b0;
            gnt_msg   <= 1'b0;
        end else if (fr_ack) begin
            gnt_valid <= 1'b0;  // released with the ack
        end else if (!gnt_valid && fr_req) begin
            gnt_valid <= 1'b1;
            gnt_msg   <= sel_msg;
        end
    end

    // each framer ack reaches exactly one sequencer, and that one is still waiting
    assert property (@(posedge clk) disable iff (counter_reset)
        fr_ack |-> $onehot({init_ack && init_req, msg_ack && msg_req}));

endmodule

`default_nettype wire

// ==== verilog/message_sequencer.sv ====
`default_nettype none

module message_sequencer #(
    parameter int CHAR_GAP_CYCLES = 150000
) (
    input  logic                 clk,
    input  logic                 counter_reset,
    input  logic                 start_lcd,
    input  lcd_driver_pkg::sel_t selective,
    input  logic                 init_done,
    input  logic                 msg_ack,
    output logic                 msg_req,
    output hd44780_pkg::nibble_t msg_nibble,
    output hd44780_pkg::rs_e     msg_rs,
    output logic                 busy,
    output logic                 done
);
    import hd44780_pkg::*;
    import lcd_driver_pkg::*;

    `include "message_table.svh"

    localparam int GAP_W    = $clog2(CHAR_GAP_CYCLES + 1);
    localparam int LAST_IDX = MSG_LEN + 1;

    msg_state_e            state;
    msg_state_e            after_gap;  // half to send once the gap runs out
    logic [GAP_W-1:0]      gap_cnt;
    logic [BYTE_IDX_W-1:0] byte_idx;   // 0 and 1 are commands, then the text
    sel_t                  sel_q;
    logic [8*MSG_LEN-1:0]  msg_text;
    logic [7:0]            cur_byte;

    //////////////////////////////////////////////////
    // byte selection
    //////////////////////////////////////////////////

    always_comb begin
        msg_text = MSG_TABLE[sel_q];
        if (byte_idx == BYTE_IDX_W'(0)) begin
            cur_byte = CMD_DISPLAY_BLINK;
        end else if (byte_idx == BYTE_IDX_W'(1)) begin
            cur_byte = CMD_DDRAM_HOME;
        end else begin
            cur_byte = msg_text[8*(LAST_IDX - int'(byte_idx)) +: 8];  // character byte_idx-2
        end
    end

    assign msg_nibble = (state == MSG_SEND_LO) ? cur_byte[3:0] : cur_byte[7:4];
    assign msg_rs     = (byte_idx < BYTE_IDX_W'(2)) ? RS_CMD : RS_DATA;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (counter_reset) begin
            state     <= MSG_IDLE;
            after_gap <= MSG_SEND_HI;
            gap_cnt   <= '0;
            byte_idx  <= '0;
            msg_req   <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                MSG_IDLE: begin
                    if (start_lcd && init_done) begin
                        // selects beyond the table show the error text
                        sel_q    <= (selective >= sel_t'(MSG_COUNT)) ? sel_t'(MSG_COUNT - 1)
                                                                     : selective;
                        byte_idx <= '0;
                        busy     <= 1'b1;
                        msg_req  <= 1'b1;
                        state    <= MSG_SEND_HI;
                    end
                end
                MSG_SEND_HI: begin
                    if (msg_ack) begin
                        msg_req   <= 1'b0;
                        after_gap <= MSG_SEND_LO;
                        gap_cnt   <= GAP_W'(CHAR_GAP_CYCLES - 1);
                        state     <= MSG_GAP;
                    end
                end
                MSG_SEND_LO: begin
                    if (msg_ack) begin
                        msg_req <= 1'b0;
                        if (byte_idx == BYTE_IDX_W'(LAST_IDX)) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= MSG_DONE;
                        end else begin
                            byte_idx  <= byte_idx + 1'b1;
                            after_gap <= MSG_SEND_HI;
                            gap_cnt   <= GAP_W'(CHAR_GAP_CYCLES - 1);
                            state     <= MSG_GAP;
                        end
                    end
                end
                MSG_GAP: begin
                    if (gap_cnt == '0) begin
                        msg_req <= 1'b1;
                        state   <= after_gap;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                MSG_DONE: begin
                    if (!start_lcd) begin
                        done  <= 1'b0;
                        state <= MSG_IDLE;
                    end
                end
                default: begin
                    state <= MSG_IDLE;
                end
            endcase
        end
    end

    // two commands and MSG_LEN characters, never further
    assert property (@(posedge clk) disable iff (counter_reset)
        byte_idx < BYTE_IDX_W'(MSG_LEN + 2));

endmodule

`default_nettype wire

// ==== verilog/init_sequencer.sv ====
`default_nettype none

module init_sequencer #(
    parameter int POWER_UP_CYCLES = 1000000,
    parameter int INIT_GAP_CYCLES = 250000
) (
    input  logic                 clk,
    input  logic                 counter_reset,
    input  logic                 init_ack,
    output logic                 init_req,
    output hd44780_pkg::nibble_t init_nibble,
    output hd44780_pkg::rs_e     init_rs,
    output logic                 init_done
);
    import hd44780_pkg::*;
    import lcd_driver_pkg::*;

    localparam int CNT_MAX = (POWER_UP_CYCLES > INIT_GAP_CYCLES) ? POWER_UP_CYCLES
                                                                  : INIT_GAP_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    init_state_e      state;
    logic [CNT_W-1:0] wait_cnt;  // power-up timer, reloaded for each gap
    logic [1:0]       step;      // nibbles acknowledged so far

    // three wake-up nibbles, the fourth selects 4-bit mode
    assign init_nibble = (step == 2'd3) ? nibble_t'(CMD_FUNC_4BIT) : nibble_t'(CMD_FUNC_8BIT);
    assign init_rs     = RS_CMD;

    always_ff @(posedge clk) begin
        if (counter_reset) begin
            state     <= INIT_WAIT;
            wait_cnt  <= CNT_W'(POWER_UP_CYCLES - 1);
            step      <= 2'd0;
            init_req  <= 1'b0;
            init_done <= 1'b0;
        end else begin
            case (state)
                INIT_WAIT, INIT_GAP: begin
                    if (wait_cnt == '0) begin
                        state    <= INIT_SEND;
                        init_req <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                INIT_SEND: begin
                    if (init_ack) begin
                        init_req <= 1'b0;  // dropped the cycle after the ack
                        step     <= step + 1'b1;
                        if (step == 2'd3) begin
                            state     <= INIT_DONE;
                            init_done <= 1'b1;
                        end else begin
                            state    <= INIT_GAP;
                            wait_cnt <= CNT_W'(INIT_GAP_CYCLES - 1);
                        end
                    end
                end
                default: begin
                    state <= INIT_DONE;  // stays here until the next reset
                end
            endcase
        end
    end

    // once the display is initialised this block never asks for the framer again
    assert property (@(posedge clk) disable iff (counter_reset)
        init_done |=> init_done && !init_req);

endmodule

`default_nettype wire

// ==== verilog/lcd_driver_pkg.sv ====
`default_nettype none

package lcd_driver_pkg;

    //////////////////////////////////////////////////
    // message geometry
    //////////////////////////////////////////////////

    localparam int MSG_LEN    = 8;  // characters per message
    localparam int MSG_COUNT  = 7;  // distinct messages in the table
    localparam int BYTE_IDX_W = $clog2(MSG_LEN + 2);  // two commands plus the text

    typedef logic [2:0] sel_t;  // message select from the user

    //////////////////////////////////////////////////
    // sequencer states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        INIT_WAIT,  // power-up delay
        INIT_SEND,  // nibble request outstanding
        INIT_GAP,   // settle time between nibbles
        INIT_DONE
    } init_state_e;

    typedef enum logic [2:0] {
        MSG_IDLE,
        MSG_SEND_HI,  // upper nibble of the current byte
        MSG_SEND_LO,  // lower nibble of the current byte
        MSG_GAP,
        MSG_DONE      // wait for start_lcd to drop
    } msg_state_e;

endpackage

`default_nettype wire

// ==== verilog/hd44780_pkg.sv ====
`default_nettype none

package hd44780_pkg;

    //////////////////////////////////////////////////
    // expander byte layout
    //////////////////////////////////////////////////

    typedef logic [3:0] nibble_t;    // data nibble, bits 7..4 of the byte
    typedef logic [7:0] exp_byte_t;  // one byte written to the expander

    localparam int EXP_BACKLIGHT = 3;  // backlight transistor
    localparam int EXP_ENABLE    = 2;  // E strobe, display latches on the fall
    localparam int EXP_RW        = 1;  // 0 for write
    localparam int EXP_RS        = 0;  // register select

    typedef enum logic {
        RS_CMD  = 1'b0,  // instruction register
        RS_DATA = 1'b1   // data register, i.e. a character
    } rs_e;

    //////////////////////////////////////////////////
    // display opcodes
    //////////////////////////////////////////////////

    // the two function-set codes are sent as a single nibble during power-up
    typedef enum logic [7:0] {
        CMD_FUNC_4BIT     = 8'h02,  // switch the interface to 4-bit mode
        CMD_FUNC_8BIT     = 8'h03,  // wake-up nibble, repeated three times
        CMD_DISPLAY_BLINK = 8'h0F,  // display on, cursor on, blinking
        CMD_DDRAM_HOME    = 8'h80   // ddram address 0, first line first column
    } cmd_e;

endpackage

`default_nettype wire

// ==== include/message_table.svh ====
`ifndef MESSAGE_TABLE_SVH
`define MESSAGE_TABLE_SVH

//////////////////////////////////////////////////
// display texts, one row per select value
//////////////////////////////////////////////////

// first character sits in the top byte of each row
localparam logic [8*MSG_LEN-1:0] MSG_TABLE [MSG_COUNT] = '{
    "Weather#",  // select 0
    "Hazelnut",  // select 1
    "Cookie##",  // select 2
    "Rulokat#",  // select 3
    "Salad###",  // select 4
    "Orange##",  // select 5
    "Error###"   // select 6, select 7 folds onto this row
};

`endif
